// File: build.f
source/cart_pkg.sv
source/cart_stage_if.sv
source/cart_header_capture.sv
source/mbc_bank_regs.sv
source/mbc_addr_map.sv
source/cart_ram_port.sv
source/cart_mapper_top.sv
verif/cart_mapper_tb.sv

// File: verif/cart_mapper_tb.sv
// ----------------------------------------------------------
// Directed testbench for the cartridge mapper
// Downloads headers, runs four-phase CPU accesses and checks
// ROM addresses and RAM read data against the MBC rules
// ----------------------------------------------------------
`timescale 1ns/1ps

module cart_mapper_tb;

	localparam int ack_timeout = 32;   // Clocks allowed per handshake phase

	logic                clk_sys;
	logic                reset;
	logic                dl_active;
	logic                dl_wr;
	logic [24:0]         dl_addr;
	cart_pkg::dl_word_t  dl_data;
	logic                req;
	cart_pkg::cpu_addr_t addr;
	logic                wr;
	cart_pkg::cpu_data_t wdata;
	logic                ack;
	cart_pkg::cpu_data_t rd_data;
	logic                rom_sel;
	cart_pkg::rom_addr_t rom_addr;

	cart_mapper_top u_cart_mapper_top (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.req       (req),
		.addr      (addr),
		.wr        (wr),
		.wdata     (wdata),
		.ack       (ack),
		.rd_data   (rd_data),
		.rom_sel   (rom_sel),
		.rom_addr  (rom_addr)
	);

	always #20 clk_sys = ~clk_sys;   // 40 ns period

	// ---- Failure handling and compares ------------------------
	task automatic stop_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		stop_run();
	endtask

	task automatic check_data(input cart_pkg::cpu_addr_t a, input cart_pkg::cpu_data_t got,
		input cart_pkg::cpu_data_t exp);
		if (got !== exp) begin
			$display("[FAIL] rd_data at 0x%h: got 0x%h, expected 0x%h", a, got, exp);
			stop_run();
		end
	endtask

	task automatic check_rom(input cart_pkg::cpu_addr_t a, input logic got_sel,
		input cart_pkg::rom_addr_t got, input cart_pkg::rom_addr_t exp);
		if (got_sel !== 1'b1) begin
			$display("[FAIL] rom_sel at 0x%h: got 0x%h, expected 0x1", a, got_sel);
			stop_run();
		end
		if (got !== exp) begin
			$display("[FAIL] rom_addr at 0x%h: got 0x%h, expected 0x%h", a, got, exp);
			stop_run();
		end
	endtask

	// 9 bit bank on top of the 14 bit offset within the window
	function automatic cart_pkg::rom_addr_t banked_rom_addr(input cart_pkg::rom_bank_t bank,
		input cart_pkg::cpu_addr_t a);
		return {bank, a[13:0]};
	endfunction

	function automatic cart_pkg::cpu_data_t random_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	// ---- Download and CPU access ------------------------------
	task automatic download_header(input logic [7:0] type_code, input logic [7:0] rom_size,
		input logic [7:0] ram_size);
		@(negedge clk_sys);
		dl_active = 1'b1;   // Rising edge clears the bank registers
		@(negedge clk_sys);
		dl_wr   = 1'b1;
		dl_addr = cart_pkg::hdr_cgb_word;
		dl_data = 16'h0000;
		@(negedge clk_sys);
		dl_addr = cart_pkg::hdr_type_word;
		dl_data = {type_code, 8'h00};   // Type byte 0x147 is the high byte
		@(negedge clk_sys);
		dl_addr = cart_pkg::hdr_size_word;
		dl_data = {ram_size, rom_size};
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
		dl_active = 1'b0;
	endtask

	task automatic cpu_cycle(input cart_pkg::cpu_addr_t a, input logic is_wr,
		input cart_pkg::cpu_data_t d, output cart_pkg::cpu_data_t data_q,
		output logic sel_q, output cart_pkg::rom_addr_t raddr_q);
		int n;
		@(negedge clk_sys);
		addr  = a;
		wr    = is_wr;
		wdata = d;
		req   = 1'b1;
		n = 0;
		while (!ack && n < ack_timeout) begin
			@(negedge clk_sys);
			n++;
		end
		if (!ack)
			report_timeout("ack never rose for the CPU access");
		data_q  = rd_data;   // Held while ack is high
		sel_q   = rom_sel;
		raddr_q = rom_addr;
		req = 1'b0;
		n = 0;
		while (ack && n < ack_timeout) begin
			@(negedge clk_sys);
			n++;
		end
		if (ack)
			report_timeout("ack stayed high after req dropped");
	endtask

	task automatic cpu_write(input cart_pkg::cpu_addr_t a, input cart_pkg::cpu_data_t d);
		cart_pkg::cpu_data_t unused_data;
		logic                unused_sel;
		cart_pkg::rom_addr_t unused_addr;
		cpu_cycle(a, 1'b1, d, unused_data, unused_sel, unused_addr);
	endtask

	task automatic cpu_read(input cart_pkg::cpu_addr_t a, output cart_pkg::cpu_data_t data_q,
		output logic sel_q, output cart_pkg::rom_addr_t raddr_q);
		cpu_cycle(a, 1'b0, 8'h00, data_q, sel_q, raddr_q);
	endtask

	task automatic expect_rom_read(input cart_pkg::cpu_addr_t a, input cart_pkg::rom_addr_t exp);
		cart_pkg::cpu_data_t data_q;
		logic                sel_q;
		cart_pkg::rom_addr_t raddr_q;
		cpu_read(a, data_q, sel_q, raddr_q);
		check_rom(a, sel_q, raddr_q, exp);
	endtask

	task automatic expect_data_read(input cart_pkg::cpu_addr_t a, input cart_pkg::cpu_data_t exp);
		cart_pkg::cpu_data_t data_q;
		logic                sel_q;
		cart_pkg::rom_addr_t raddr_q;
		cpu_read(a, data_q, sel_q, raddr_q);
		check_data(a, data_q, exp);
	endtask

	// ---- Directed tests ---------------------------------------
	task automatic test_plain_rom();
		cart_pkg::cpu_data_t b;
		cart_pkg::cpu_addr_t a;
		download_header(8'h00, 8'h00, 8'h02);   // ROM only
		expect_rom_read(16'h0000, 23'h000000);
		expect_rom_read(16'h3FFF, 23'h003FFF);
		expect_rom_read(16'h4000, 23'h004000);
		expect_rom_read(16'h7FFF, 23'h007FFF);
		for (int i = 0; i < 4; i++) begin
			b = random_byte();
			a = {1'b0, b[6:0], random_byte()};
			expect_rom_read(a, {7'd0, a});   // Linear mapping
		end
		expect_data_read(16'hA000, 8'hFF);   // RAM still disabled
		cpu_write(16'h0000, 8'h0A);
		b = random_byte();
		if (b == 8'hFF)
			b = 8'h5A;   // Must differ from the disabled read value
		cpu_write(16'hA000, b);
		expect_data_read(16'hA000, b);
		cpu_write(16'h0000, 8'h00);
		expect_data_read(16'hA000, 8'hFF);
	endtask

	task automatic test_mbc1_banks();
		download_header(8'h01, 8'h05, 8'h03);   // 64 ROM banks
		cpu_write(16'h2000, 8'h03);
		cpu_write(16'h2000, 8'h00);
		expect_rom_read(16'h4000, banked_rom_addr(9'd1, 16'h4000));   // 0 selects 1
		cpu_write(16'h2000, 8'h45);
		expect_rom_read(16'h4567, banked_rom_addr(9'h45 & 9'd63, 16'h4567));
		cpu_write(16'h6000, 8'h01);   // Mode 1
		cpu_write(16'h4000, 8'h01);   // Upper bank bits = 1
		expect_rom_read(16'h0123, banked_rom_addr(9'd32, 16'h0123));
		expect_rom_read(16'h4000, banked_rom_addr(((9'd1 << 5) | 9'h05) & 9'd63, 16'h4000));
		cpu_write(16'h4000, 8'h03);   // Top bank bit lies above the 64 bank mask
		expect_rom_read(16'h4000, banked_rom_addr(((9'd3 << 5) | 9'h05) & 9'd63, 16'h4000));
	endtask

	task automatic test_mbc5_banks();
		download_header(8'h19, 8'h08, 8'h00);   // 512 ROM banks
		cpu_write(16'h2000, 8'h23);
		cpu_write(16'h3000, 8'h01);
		expect_rom_read(16'h4ABC, banked_rom_addr(9'h123, 16'h4ABC));
		expect_rom_read(16'h1234, banked_rom_addr(9'd0, 16'h1234));
		cpu_write(16'h2000, 8'h00);
		cpu_write(16'h3000, 8'h00);
		expect_rom_read(16'h4000, banked_rom_addr(9'd0, 16'h4000));   // MBC5 allows bank 0
	endtask

	task automatic test_ram_banks();
		cart_pkg::cpu_data_t b0;
		cart_pkg::cpu_data_t b1;
		download_header(8'h1B, 8'h08, 8'h04);   // MBC5 with 16 RAM banks
		expect_data_read(16'hA000, 8'hFF);
		cpu_write(16'h0000, 8'h0A);
		b0 = random_byte();
		b1 = random_byte();
		if (b1 == b0)
			b1 = ~b0;   // Keep the banks distinguishable
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'hA010, b0);
		cpu_write(16'h4000, 8'h03);
		cpu_write(16'hA010, b1);
		expect_data_read(16'hA010, b1);
		cpu_write(16'h4000, 8'h00);
		expect_data_read(16'hA010, b0);
	endtask

	task automatic test_mbc2_nibbles();
		cart_pkg::cpu_data_t b;
		download_header(8'h06, 8'h03, 8'h00);
		cpu_write(16'h0000, 8'h0A);
		b = random_byte();
		b[7] = 1'b0;   // Stored upper nibble never F
		cpu_write(16'hA005, b);
		expect_data_read(16'hA005, {4'hF, b[3:0]});   // 4 bit cells
		b = random_byte();
		b[7] = 1'b0;
		cpu_write(16'hA1FF, b);
		expect_data_read(16'hA1FF, {4'hF, b[3:0]});
	endtask

	task automatic test_mbc3_clock();
		cart_pkg::cpu_data_t b0;
		cart_pkg::cpu_data_t b1;
		download_header(8'h13, 8'h06, 8'h03);
		cpu_write(16'h0000, 8'h0A);
		b0 = random_byte();
		b0[7] = 1'b0;   // Keeps b1 away from the clock mode value 0x00
		b1 = ~b0;
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'hA020, b0);
		cpu_write(16'h4000, 8'h01);
		cpu_write(16'hA020, b1);
		expect_data_read(16'hA020, b1);
		cpu_write(16'h4000, 8'h08);   // Clock register select
		expect_data_read(16'hA020, 8'h00);
		cpu_write(16'h4000, 8'h01);
		expect_data_read(16'hA020, b1);
	endtask

	task automatic test_download_reset();
		cpu_write(16'h2000, 8'h05);   // Still MBC3 from the previous test
		expect_rom_read(16'h4000, banked_rom_addr(9'd5, 16'h4000));
		download_header(8'h13, 8'h06, 8'h03);
		expect_rom_read(16'h4000, banked_rom_addr(9'd1, 16'h4000));
		expect_data_read(16'hA020, 8'hFF);   // Enable cleared too
	endtask

	// ---- Sequence ---------------------------------------------
	initial begin
		void'($urandom(7));
		clk_sys   = 1'b0;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		req       = 1'b0;
		addr      = '0;
		wr        = 1'b0;
		wdata     = '0;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		test_plain_rom();
		test_mbc1_banks();
		test_mbc5_banks();
		test_ram_banks();
		test_mbc2_nibbles();
		test_mbc3_clock();
		test_download_reset();

		$display("Test passed");
		$finish;
	end

endmodule

// File: source/cart_mapper_top.sv
// ----------------------------------------------------------
// Cartridge mapper top level
// Four-phase req/ack CPU port in front of the three stage
// bank, address map and RAM pipeline; header capture runs
// alongside on the download stream
// ----------------------------------------------------------
`timescale 1ns/1ps

module cart_mapper_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                dl_active,
	input  logic                dl_wr,
	input  logic [24:0]         dl_addr,
	input  cart_pkg::dl_word_t  dl_data,
	input  logic                req,
	input  cart_pkg::cpu_addr_t addr,
	input  logic                wr,
	input  cart_pkg::cpu_data_t wdata,
	output logic                ack,
	output cart_pkg::cpu_data_t rd_data,
	output logic                rom_sel,
	output cart_pkg::rom_addr_t rom_addr
);

	typedef enum logic [1:0] {
		fe_idle,   // Waiting for req
		fe_busy,   // Item in the pipeline
		fe_done    // ack high, waiting for req to drop
	} fe_state_t;

	fe_state_t             fe_state;
	cart_pkg::cart_info_t  info;
	cart_pkg::cpu_access_t cpu_in;
	logic                  cpu_valid;
	logic                  cpu_ready;
	logic                  rsp_valid;
	logic                  rsp_ready;

	cart_stage_if #(.payload_t(cart_pkg::banked_access_t)) bank_link ();
	cart_stage_if #(.payload_t(cart_pkg::mapped_access_t)) map_link ();

	// ---- CPU front end ---------------------------------------
	assign cpu_in.addr  = addr;   // CPU holds these while req is high
	assign cpu_in.wr    = wr;
	assign cpu_in.wdata = wdata;

	// Response stays parked in the RAM stage until req falls
	assign rsp_ready = (fe_state == fe_done) && !req;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fe_state  <= fe_idle;
			cpu_valid <= 1'b0;
			ack       <= 1'b0;
		end else begin
			case (fe_state)
				fe_idle:
					if (req) begin
						cpu_valid <= 1'b1;   // Launch one item
						fe_state  <= fe_busy;
					end
				fe_busy: begin
					if (cpu_valid && cpu_ready)
						cpu_valid <= 1'b0;
					if (rsp_valid) begin
						ack      <= 1'b1;
						fe_state <= fe_done;
					end
				end
				default:
					if (!req) begin
						ack      <= 1'b0;
						fe_state <= fe_idle;
					end
			endcase
		end
	end

	// ---- Stages ----------------------------------------------
	cart_header_capture u_header (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.info      (info)
	);

	mbc_bank_regs u_bank_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.info      (info),
		.cpu_in    (cpu_in),
		.cpu_valid (cpu_valid),
		.cpu_ready (cpu_ready),
		.out_link  (bank_link.source)
	);

	mbc_addr_map u_addr_map (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.info     (info),
		.in_link  (bank_link.sink),
		.out_link (map_link.source)
	);

	cart_ram_port u_ram_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.in_link   (map_link.sink),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rd_data   (rd_data),
		.rom_sel   (rom_sel),
		.rom_addr  (rom_addr)
	);

endmodule

// File: source/cart_ram_port.sv
// ----------------------------------------------------------
// Cartridge RAM stage
// 128 KiB of banked cart RAM with a synchronous read port
// Forms the CPU read value and passes ROM addresses out
// ----------------------------------------------------------
`timescale 1ns/1ps

module cart_ram_port (
	input  logic                clk_sys,
	input  logic                reset,
	cart_stage_if.sink          in_link,
	output logic                rsp_valid,
	input  logic                rsp_ready,
	output cart_pkg::cpu_data_t rd_data,
	output logic                rom_sel,
	output cart_pkg::rom_addr_t rom_addr
);

	cart_pkg::cpu_data_t      mem [0:cart_pkg::cart_ram_bytes-1];
	cart_pkg::mapped_access_t in_item;
	cart_pkg::cpu_data_t      ram_q;        // Registered array output
	logic                     take;
	logic                     ram_wr;
	logic                     rsp_is_ram;
	logic                     rsp_enable;
	logic                     rsp_rtc;
	logic                     rsp_nibble;

	assign in_item       = in_link.payload;
	assign in_link.ready = ~rsp_valid | rsp_ready;   // Hold while CPU side waits
	assign take          = in_link.valid & in_link.ready;
	assign ram_wr        = take & in_item.is_ram & in_item.wr & in_item.ram_enable;

	// ---- RAM array -------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (ram_wr)
			mem[in_item.ram_addr] <= in_item.wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (take)
			ram_q <= mem[in_item.ram_addr];   // Read first on a write
	end

	// ---- Response register -----------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset)
			rsp_valid <= 1'b0;
		else if (take)
			rsp_valid <= 1'b1;
		else if (rsp_ready)
			rsp_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			rom_sel    <= in_item.is_rom;
			rom_addr   <= in_item.rom_addr;
			rsp_is_ram <= in_item.is_ram;
			rsp_enable <= in_item.ram_enable;
			rsp_rtc    <= in_item.rtc_mode;
			rsp_nibble <= in_item.nibble_ram;
		end
	end

	// Read value after the array register
	always_comb begin
		if (!rsp_is_ram || !rsp_enable)
			rd_data = 8'hFF;                   // Disabled or not a RAM access
		else if (rsp_rtc)
			rd_data = 8'h00;                   // MBC3 clock registers selected
		else if (rsp_nibble)
			rd_data = {4'hF, ram_q[3:0]};      // MBC2 keeps only the low nibble
		else
			rd_data = ram_q;
	end

endmodule

// File: source/mbc_addr_map.sv
// ----------------------------------------------------------
// Address map stage
// Turns a tagged CPU access into a ROM byte address or a
// cartridge RAM address for the current MBC kind
// ----------------------------------------------------------
`timescale 1ns/1ps

module mbc_addr_map (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::cart_info_t info,
	cart_stage_if.sink           in_link,
	cart_stage_if.source         out_link
);

	cart_pkg::banked_access_t in_item;
	cart_pkg::mapped_access_t mapped;
	cart_pkg::mapped_access_t out_item;
	cart_pkg::rom_bank_t      cur_bank;     // 0 in the low ROM region
	cart_pkg::rom_bank_t      rom_bank;
	cart_pkg::ram_bank_t      ram_bank;
	logic [1:0]               mbc1_bank2;   // MBC1 upper bank bits
	logic [6:0]               mbc1_bank;
	logic                     out_valid;
	logic                     take;

	assign in_item       = in_link.payload;
	assign in_link.ready = ~out_valid | out_link.ready;
	assign take          = in_link.valid & in_link.ready;

	always_comb begin
		cur_bank   = in_item.acc.addr[14] ? in_item.bank.rom_bank : '0;
		// Mode 0 keeps bank2 off the low ROM region and RAM
		mbc1_bank2 = in_item.bank.ram_bank[1:0] &
			{2{in_item.acc.addr[14] | in_item.bank.mbc1_mode}};
		mbc1_bank  = {mbc1_bank2, cur_bank[4:0]} & info.rom_mask[6:0];
		case (info.kind)
			cart_pkg::mbc1: begin
				rom_bank = {2'b00, mbc1_bank};
				ram_bank = {2'b00, mbc1_bank2 & info.ram_mask[1:0]};
			end
			cart_pkg::mbc2: begin
				rom_bank = {5'd0, cur_bank[3:0] & info.rom_mask[3:0]};   // 16 banks
				ram_bank = '0;   // Single 512 x 4 bit RAM
			end
			cart_pkg::mbc3: begin
				rom_bank = {2'b00, cur_bank[6:0] & info.rom_mask[6:0]};
				ram_bank = {2'b00, in_item.bank.ram_bank[1:0] & info.ram_mask[1:0]};
			end
			cart_pkg::mbc5: begin
				rom_bank = cur_bank & info.rom_mask;
				ram_bank = in_item.bank.ram_bank & info.ram_mask;
			end
			default: begin
				rom_bank = {8'd0, in_item.acc.addr[14]};   // Plain 32 KiB ROM
				ram_bank = '0;
			end
		endcase

		mapped.is_rom     = ~in_item.acc.addr[15];
		mapped.is_ram     = (in_item.acc.addr[15:13] == cart_pkg::region_cart_ram);
		mapped.wr         = in_item.acc.wr;
		mapped.rom_addr   = {rom_bank, in_item.acc.addr[13:0]};
		mapped.ram_addr   = {ram_bank, in_item.acc.addr[12:0]};
		mapped.wdata      = in_item.acc.wdata;
		mapped.ram_enable = in_item.bank.ram_enable;
		mapped.rtc_mode   = in_item.bank.rtc_mode;
		mapped.nibble_ram = (info.kind == cart_pkg::mbc2) &&
			(in_item.acc.addr[15:9] == 7'b1010000);   // 0xA000 to 0xA1FF
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			out_valid <= 1'b0;
		else if (take)
			out_valid <= 1'b1;
		else if (out_link.ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (take)
			out_item <= mapped;
	end

	assign out_link.valid   = out_valid;
	assign out_link.payload = out_item;

endmodule

// File: source/mbc_bank_regs.sv
// ----------------------------------------------------------
// Bank register stage
// Applies CPU writes to the MBC bank registers and forwards
// each access tagged with the bank state it saw
// ----------------------------------------------------------
`timescale 1ns/1ps

module mbc_bank_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  cart_pkg::cart_info_t  info,
	input  cart_pkg::cpu_access_t cpu_in,
	input  logic                  cpu_valid,
	output logic                  cpu_ready,
	cart_stage_if.source          out_link
);

	cart_pkg::bank_state_t    bank;        // Live register state
	cart_pkg::banked_access_t out_item;
	logic                     out_valid;
	logic                     dl_active_q;
	logic                     dl_start;    // New image download begins
	logic                     take;
	logic                     is_mbc5;
	logic [2:0]               region;

	assign cpu_ready = ~out_valid | out_link.ready;   // Empty or draining
	assign take      = cpu_valid & cpu_ready;
	assign region    = cpu_in.addr[15:13];
	assign is_mbc5   = (info.kind == cart_pkg::mbc5);
	assign dl_start  = dl_active & ~dl_active_q;

	always_ff @(posedge clk_sys) begin
		if (reset)
			dl_active_q <= 1'b0;
		else
			dl_active_q <= dl_active;
	end

	// ---- Register writes -------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_start) begin
			bank.rom_bank   <= cart_pkg::rom_bank_reset;
			bank.ram_bank   <= '0;
			bank.mbc1_mode  <= 1'b0;
			bank.rtc_mode   <= 1'b0;
			bank.ram_enable <= 1'b0;
		end else if (take && cpu_in.wr) begin
			case (region)
				cart_pkg::region_ram_enable:
					bank.ram_enable <= (cpu_in.wdata[3:0] == cart_pkg::ram_enable_code);
				cart_pkg::region_rom_bank: begin
					if (is_mbc5) begin
						if (cpu_in.addr[12])
							bank.rom_bank[8] <= cpu_in.wdata[0];   // 0x3000 high bit
						else
							bank.rom_bank[7:0] <= cpu_in.wdata;    // 0x2000 low byte
					end else if (cpu_in.wdata[6:0] == 7'd0) begin
						bank.rom_bank <= cart_pkg::rom_bank_reset;  // Bank 0 maps to 1
					end else begin
						bank.rom_bank <= {2'b00, cpu_in.wdata[6:0]};
					end
				end
				cart_pkg::region_ram_bank: begin
					if (info.kind == cart_pkg::mbc3) begin
						bank.rtc_mode <= cpu_in.wdata[3];   // Clock register select
						if (!cpu_in.wdata[3])
							bank.ram_bank <= {2'b00, cpu_in.wdata[1:0]};
					end else if (is_mbc5) begin
						bank.ram_bank <= cpu_in.wdata[3:0];
					end else begin
						bank.ram_bank <= {2'b00, cpu_in.wdata[1:0]};
					end
				end
				cart_pkg::region_mode:
					if (info.kind == cart_pkg::mbc1)
						bank.mbc1_mode <= cpu_in.wdata[0];
				default: ;
			endcase
		end
	end

	// ---- Output register -------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset)
			out_valid <= 1'b0;
		else if (take)
			out_valid <= 1'b1;
		else if (out_link.ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			out_item.acc  <= cpu_in;
			out_item.bank <= bank;   // State before this write
		end
	end

	assign out_link.valid   = out_valid;
	assign out_link.payload = out_item;

endmodule

// File: source/cart_header_capture.sv
// ----------------------------------------------------------
// Cartridge header capture
// Watches the download stream for the type and size words
// and derives the MBC kind plus ROM and RAM bank masks
// ----------------------------------------------------------
`timescale 1ns/1ps

module cart_header_capture (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dl_active,
	input  logic                 dl_wr,
	input  logic [24:0]          dl_addr,
	input  cart_pkg::dl_word_t   dl_data,
	output cart_pkg::cart_info_t info
);

	logic [7:0] type_byte;   // Cartridge type at 0x147
	logic [7:0] rom_size;    // ROM size code at 0x148
	logic [7:0] ram_size;    // RAM size code at 0x149
	logic [9:0] rom_span;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= '0;
			rom_size  <= '0;
			ram_size  <= '0;
		end else if (dl_active && dl_wr) begin
			case (dl_addr)
				cart_pkg::hdr_type_word: type_byte <= dl_data[15:8];
				cart_pkg::hdr_size_word: begin
					rom_size <= dl_data[7:0];
					ram_size <= dl_data[15:8];
				end
				default: ;
			endcase
		end
	end

	// ---- Kind decode -----------------------------------------
	always_comb begin
		if (type_byte inside {[8'd1:8'd3]})
			info.kind = cart_pkg::mbc1;
		else if (type_byte inside {[8'd5:8'd6]})
			info.kind = cart_pkg::mbc2;
		else if (type_byte inside {[8'd15:8'd19]})
			info.kind = cart_pkg::mbc3;
		else if (type_byte inside {[8'd25:8'd30]})
			info.kind = cart_pkg::mbc5;
		else
			info.kind = cart_pkg::none;   // ROM only or unsupported
	end

	// 2 banks for size 0 and 512 banks at size 8
	assign rom_span = (10'd2 << rom_size[3:0]) - 10'd1;
	assign info.rom_mask = (rom_size <= 8'd8) ? rom_span[8:0] : 9'd127;

	// Sizes 0 to 2 fit in one bank and size 3 has four
	assign info.ram_mask = (ram_size <= 8'd2) ? 4'd0 :
		(ram_size == 8'd3) ? 4'd3 : 4'd15;

endmodule

// File: source/cart_stage_if.sv
// ----------------------------------------------------------
// Valid/ready link between two mapper pipeline stages
// Producer uses source, consumer uses sink
// ----------------------------------------------------------
`timescale 1ns/1ps

interface cart_stage_if #(
	parameter type payload_t = cart_pkg::mapped_access_t
);

	logic     valid;     // Payload present
	logic     ready;     // Consumer can take it
	payload_t payload;

	// Transfer on any clock with valid and ready both high
	modport source (
		output valid,
		output payload,
		input  ready
	);

	modport sink (
		input  valid,
		input  payload,
		output ready
	);

endinterface

// File: source/cart_pkg.sv
// ----------------------------------------------------------
// Shared types and constants for the cartridge mapper
// Address regions, header word offsets, MBC kinds and the
// structs that travel between the pipeline stages
// ----------------------------------------------------------
package cart_pkg;

	typedef logic [15:0] cpu_addr_t;   // CPU address bus
	typedef logic [7:0]  cpu_data_t;   // CPU data bus
	typedef logic [15:0] dl_word_t;    // Download data word
	typedef logic [22:0] rom_addr_t;   // 9 bit bank + 14 bit offset
	typedef logic [16:0] ram_addr_t;   // 4 bit bank + 13 bit offset
	typedef logic [8:0]  rom_bank_t;
	typedef logic [3:0]  ram_bank_t;

	typedef enum logic [2:0] {
		none,
		mbc1,
		mbc2,
		mbc3,
		mbc5
	} mbc_kind_t;

	// Header words, byte addresses in the download stream
	localparam logic [24:0] hdr_cgb_word  = 25'h142;
	localparam logic [24:0] hdr_type_word = 25'h146;   // High byte is cart type
	localparam logic [24:0] hdr_size_word = 25'h148;   // Low ROM size, high RAM size

	localparam logic [3:0] ram_enable_code = 4'hA;
	localparam rom_bank_t  rom_bank_reset  = 9'd1;
	localparam int unsigned cart_ram_bytes = 1 << 17;   // 16 banks of 8 KiB

	// CPU address regions, top three address bits
	localparam logic [2:0] region_ram_enable = 3'b000;
	localparam logic [2:0] region_rom_bank   = 3'b001;
	localparam logic [2:0] region_ram_bank   = 3'b010;
	localparam logic [2:0] region_mode       = 3'b011;
	localparam logic [2:0] region_cart_ram   = 3'b101;

	typedef struct packed {
		mbc_kind_t  kind;
		logic [8:0] rom_mask;
		logic [3:0] ram_mask;
	} cart_info_t;

	typedef struct packed {
		cpu_addr_t addr;
		logic      wr;
		cpu_data_t wdata;
	} cpu_access_t;

	// Bank register snapshot taken with each access
	typedef struct packed {
		rom_bank_t rom_bank;
		ram_bank_t ram_bank;
		logic      mbc1_mode;
		logic      rtc_mode;
		logic      ram_enable;
	} bank_state_t;

	typedef struct packed {
		cpu_access_t acc;
		bank_state_t bank;
	} banked_access_t;

	typedef struct packed {
		logic      is_rom;
		logic      is_ram;
		logic      wr;
		rom_addr_t rom_addr;
		ram_addr_t ram_addr;
		cpu_data_t wdata;
		logic      ram_enable;
		logic      rtc_mode;
		logic      nibble_ram;   // MBC2 4 bit RAM
	} mapped_access_t;

endpackage
